// File: rtl/core_pkg.sv
//----------------------------------------------------------
// Shared widths, stack depths and encodings of the core
// Opcodes not listed in opcode_e execute as NOP
//----------------------------------------------------------
package core_pkg;

	// Word and address widths
	localparam int DATA_W  = 16;
	localparam int IADDR_W = 9;
	localparam int DADDR_W = 9;
	localparam int OPCO_W  = 7;
	localparam int OPER_W  = 9;
	localparam int IO_W    = 3;

	// Return-address stack and data stack
	localparam int ISTACK_DEPTH = 8;
	localparam int DSTACK_DEPTH = 8;

	typedef logic [DATA_W-1:0]        data_t;
	typedef logic [IADDR_W-1:0]       iaddr_t;
	typedef logic [DADDR_W-1:0]       daddr_t;
	typedef logic [OPER_W-1:0]        operand_t;
	typedef logic [OPCO_W+OPER_W-1:0] instr_t;
	typedef logic [IO_W-1:0]          io_addr_t;

	// Instruction codes, upper OPCO_W bits of the word
	typedef enum logic [OPCO_W-1:0] {
		NOP = 7'd0,
		LOD = 7'd1,
		SET = 7'd2,
		PSH = 7'd3,
		ADD = 7'd4,
		AND = 7'd5,
		XOR = 7'd6,
		INN = 7'd7,
		OUT = 7'd8,
		CNS = 7'd9,
		JMP = 7'd13,
		JIZ = 7'd14,
		CAL = 7'd15,
		RET = 7'd16
	} opcode_e;

	// Fetch action requested by decode
	typedef enum logic [1:0] {BR_NONE, BR_JUMP, BR_CALL, BR_RET} branch_e;

	// ALU function, PASS forwards the selected operand
	typedef enum logic [1:0] {ALU_PASS, ALU_ADD, ALU_AND, ALU_XOR} alu_op_e;

	// First ALU operand
	typedef enum logic [1:0] {SRC_MEM, SRC_IO, SRC_STACK, SRC_CONST} src_e;

endpackage

// File: rtl/lifo_stack.sv
//----------------------------------------------------------
// Pointer LIFO with combinational top of stack
// DEPTH must be a power of two and at least 2
// Overflow and underflow wrap, push with pop unsupported
//----------------------------------------------------------
`timescale 1ns/100ps

module lifo_stack #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	// Entries, contents undefined after reset
	logic [WIDTH-1:0] mem [DEPTH];

	// Points at the next free entry
	logic [$clog2(DEPTH)-1:0] ptr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= '0;
		else if (push)
			ptr <= ptr + 1'b1;
		else if (pop)
			ptr <= ptr - 1'b1;
	end

	// Write into the free slot
	always_ff @(posedge clk) begin
		if (push)
			mem[ptr] <= din;
	end

	// Top is the entry just below the pointer
	assign dout = mem[ptr - 1'b1];

endmodule

// File: rtl/instr_fetch.sv
//----------------------------------------------------------
// Program counter and next fetch address, zero latency
// instr_addr depends combinationally on branch and target
// Return stack depth ISTACK_DEPTH, nesting beyond it is lost
//----------------------------------------------------------
`timescale 1ns/100ps

module instr_fetch import core_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  branch_e branch,
	input  iaddr_t  target,
	output iaddr_t  instr_addr
);

	//------------------------------------------------------
	// Program counter
	//------------------------------------------------------

	// Address following the word now on instr
	iaddr_t pc;

	// Return stack top
	iaddr_t ret_addr;

	logic ret_push;
	logic ret_pop;

	assign ret_push = (branch == BR_CALL);
	assign ret_pop  = (branch == BR_RET);

	// Always advance past the address being fetched
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= '0;
		else
			pc <= instr_addr + 1'b1;
	end

	//------------------------------------------------------
	// Next fetch address
	//------------------------------------------------------

	always_comb begin
		case (branch)
			BR_JUMP:
				instr_addr = target;
			BR_CALL:
				instr_addr = target;
			// Resume after the call
			BR_RET:
				instr_addr = ret_addr;
			default:
				instr_addr = pc;
		endcase
	end

	//------------------------------------------------------
	// Return-address stack
	//------------------------------------------------------

	// PC already holds call address + 1
	lifo_stack #(
		.DEPTH(ISTACK_DEPTH),
		.WIDTH(IADDR_W)
	) u_ret_stack (
		.clk (clk),
		.rst (rst),
		.push(ret_push),
		.pop (ret_pop),
		.din (pc),
		.dout(ret_addr)
	);

endmodule

// File: rtl/instr_decode.sv
//----------------------------------------------------------
// Splits the word, drives stage-1 outputs combinationally
// Stage-2 controls registered, NOP holds the accumulator
//----------------------------------------------------------
`timescale 1ns/100ps

module instr_decode import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  instr_t   instr,
	input  logic     acc_bit0,
	output branch_e  branch,
	output iaddr_t   target,
	output daddr_t   mem_addr_rd,
	output logic     req_in,
	output io_addr_t addr_in,
	output alu_op_e  alu_op,
	output src_e     src,
	output logic     dpush,
	output logic     dpop,
	output data_t    const_val,
	output logic     wr_q,
	output logic     out_q,
	output daddr_t   port_q
);

	opcode_e  opcode;
	operand_t operand;
	logic     jiz_taken;

	// Next-cycle controls
	alu_op_e  alu_d;
	src_e     src_d;
	logic     push_d;
	logic     pop_d;
	data_t    const_d;
	logic     wr_d;
	logic     out_d;

	assign opcode  = opcode_e'(instr[OPCO_W+OPER_W-1:OPER_W]);
	assign operand = instr[OPER_W-1:0];

	//------------------------------------------------------
	// Stage 1
	//------------------------------------------------------

	// Forwarded bit of the accumulator written this cycle
	assign jiz_taken = (opcode == JIZ) && !acc_bit0;

	always_comb begin
		case (opcode)
			JMP:
				branch = BR_JUMP;
			JIZ:
				branch = jiz_taken ? BR_JUMP : BR_NONE;
			CAL:
				branch = BR_CALL;
			RET:
				branch = BR_RET;
			default:
				branch = BR_NONE;
		endcase
	end

	assign target      = iaddr_t'(operand);
	// Read issued for every word, used only by LOD
	assign mem_addr_rd = daddr_t'(operand);
	assign req_in      = (opcode == INN);
	assign addr_in     = operand[IO_W-1:0];

	//------------------------------------------------------
	// Stage-2 controls
	//------------------------------------------------------

	always_comb begin
		// Default keeps acc, XOR with zero
		alu_d   = ALU_XOR;
		src_d   = SRC_CONST;
		push_d  = 1'b0;
		pop_d   = 1'b0;
		const_d = '0;
		wr_d    = 1'b0;
		out_d   = 1'b0;
		case (opcode)
			LOD: begin
				push_d = 1'b1;
				src_d  = SRC_MEM;
				alu_d  = ALU_PASS;
			end
			SET:
				wr_d = 1'b1;
			PSH:
				push_d = 1'b1;
			ADD: begin
				pop_d = 1'b1;
				src_d = SRC_STACK;
				alu_d = ALU_ADD;
			end
			AND: begin
				pop_d = 1'b1;
				src_d = SRC_STACK;
				alu_d = ALU_AND;
			end
			XOR: begin
				pop_d = 1'b1;
				src_d = SRC_STACK;
				alu_d = ALU_XOR;
			end
			INN: begin
				push_d = 1'b1;
				src_d  = SRC_IO;
				alu_d  = ALU_PASS;
			end
			OUT:
				out_d = 1'b1;
			CNS: begin
				push_d  = 1'b1;
				alu_d   = ALU_PASS;
				// Zero-extended operand
				const_d = data_t'(operand);
			end
			default: begin
				alu_d = ALU_XOR;
			end
		endcase
	end

	// Reset state equals a decoded NOP
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_op    <= ALU_XOR;
			src       <= SRC_CONST;
			dpush     <= 1'b0;
			dpop      <= 1'b0;
			const_val <= '0;
			wr_q      <= 1'b0;
			out_q     <= 1'b0;
			port_q    <= '0;
		end else begin
			alu_op    <= alu_d;
			src       <= src_d;
			dpush     <= push_d;
			dpop      <= pop_d;
			const_val <= const_d;
			wr_q      <= wr_d;
			out_q     <= out_d;
			port_q    <= daddr_t'(operand);
		end
	end

endmodule

// File: rtl/execute.sv
//----------------------------------------------------------
// Stage 2, ALU, accumulator and data stack
// mem_data_rd and io_in must be valid one cycle after request
// mem_data_wr is the accumulator and also carries OUT data
//----------------------------------------------------------
`timescale 1ns/100ps

module execute import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  alu_op_e  alu_op,
	input  src_e     src,
	input  logic     dpush,
	input  logic     dpop,
	input  data_t    const_val,
	input  logic     wr_q,
	input  logic     out_q,
	input  daddr_t   port_q,
	input  data_t    mem_data_rd,
	input  data_t    io_in,
	output logic     acc_bit0,
	output logic     mem_wr,
	output daddr_t   mem_addr_wr,
	output data_t    mem_data_wr,
	output logic     out_en,
	output io_addr_t addr_out
);

	data_t acc;
	data_t stack_top;
	data_t alu_in;
	data_t alu_res;

	//------------------------------------------------------
	// Operand select and ALU
	//------------------------------------------------------

	always_comb begin
		case (src)
			SRC_MEM:
				alu_in = mem_data_rd;
			SRC_IO:
				alu_in = io_in;
			// Value leaving the stack this cycle
			SRC_STACK:
				alu_in = stack_top;
			default:
				alu_in = const_val;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_ADD:
				alu_res = alu_in + acc;
			ALU_AND:
				alu_res = alu_in & acc;
			ALU_XOR:
				alu_res = alu_in ^ acc;
			default:
				alu_res = alu_in;
		endcase
	end

	// New accumulator every cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else
			acc <= alu_res;
	end

	// Forwarded to decode for JIZ
	assign acc_bit0 = alu_res[0];

	//------------------------------------------------------
	// Data stack, old accumulator goes in
	//------------------------------------------------------

	lifo_stack #(
		.DEPTH(DSTACK_DEPTH),
		.WIDTH(DATA_W)
	) u_data_stack (
		.clk (clk),
		.rst (rst),
		.push(dpush),
		.pop (dpop),
		.din (acc),
		.dout(stack_top)
	);

	// Store and output strobes
	assign mem_wr      = wr_q;
	assign mem_addr_wr = port_q;
	assign mem_data_wr = acc;
	assign out_en      = out_q;
	assign addr_out    = port_q[IO_W-1:0];

endmodule

// File: rtl/stack_core.sv
//----------------------------------------------------------
// Stack processor core, one instruction per cycle
// Synchronous memories and registered io_in expected outside
// No stall, stack overflow and underflow are undefined
//----------------------------------------------------------
`timescale 1ns/100ps

module stack_core import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  instr_t   instr,
	output iaddr_t   instr_addr,
	output daddr_t   mem_addr_rd,
	input  data_t    mem_data_rd,
	output logic     mem_wr,
	output daddr_t   mem_addr_wr,
	output data_t    mem_data_wr,
	output logic     req_in,
	output io_addr_t addr_in,
	input  data_t    io_in,
	output logic     out_en,
	output io_addr_t addr_out
);

	// Decode to fetch
	branch_e branch;
	iaddr_t  target;

	// Execute to decode
	logic    acc_bit0;

	// Registered controls
	alu_op_e alu_op;
	src_e    src;
	logic    dpush;
	logic    dpop;
	data_t   const_val;
	logic    wr_q;
	logic    out_q;
	daddr_t  port_q;

	instr_fetch u_fetch (
		.clk       (clk),
		.rst       (rst),
		.branch    (branch),
		.target    (target),
		.instr_addr(instr_addr)
	);

	instr_decode u_decode (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.acc_bit0   (acc_bit0),
		.branch     (branch),
		.target     (target),
		.mem_addr_rd(mem_addr_rd),
		.req_in     (req_in),
		.addr_in    (addr_in),
		.alu_op     (alu_op),
		.src        (src),
		.dpush      (dpush),
		.dpop       (dpop),
		.const_val  (const_val),
		.wr_q       (wr_q),
		.out_q      (out_q),
		.port_q     (port_q)
	);

	execute u_execute (
		.clk        (clk),
		.rst        (rst),
		.alu_op     (alu_op),
		.src        (src),
		.dpush      (dpush),
		.dpop       (dpop),
		.const_val  (const_val),
		.wr_q       (wr_q),
		.out_q      (out_q),
		.port_q     (port_q),
		.mem_data_rd(mem_data_rd),
		.io_in      (io_in),
		.acc_bit0   (acc_bit0),
		.mem_wr     (mem_wr),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_wr(mem_data_wr),
		.out_en     (out_en),
		.addr_out   (addr_out)
	);

endmodule

// File: testbench/tb_clock.sv
//----------------------------------------------------------
// Testbench clock, 4 ns period
// Reset high for the first 3 rising edges
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Released on the third edge
	initial begin
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: testbench/core_properties.sv
//----------------------------------------------------------
// Port checks bound into stack_core
// Reset checks start from the second sampled reset edge
//----------------------------------------------------------
`timescale 1ns/100ps

module core_properties import core_pkg::*; (
	input logic   clk,
	input logic   rst,
	input iaddr_t instr_addr,
	input logic   mem_wr,
	input logic   out_en,
	input logic   req_in
);

	// No strobe while reset holds
	strobes_low_in_reset: assert property (
		@(posedge clk) (rst && $past(rst)) |-> (!mem_wr && !out_en && !req_in)
	) else $error("strobe active during reset");

	// Store and output share the data port
	store_output_exclusive: assert property (
		@(posedge clk) disable iff (rst) !(mem_wr && out_en)
	) else $error("mem_wr and out_en high in the same cycle");

	// Fetch address held at zero through reset
	fetch_addr_held: assert property (
		@(posedge clk) (rst && $past(rst)) |-> (instr_addr == '0)
	) else $error("instr_addr moved during reset");

endmodule

// File: testbench/tb_stack_core.sv
//----------------------------------------------------------
// Random program testbench with an ISA model of the core
// Words are made at fetch time, stack depths kept legal
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_stack_core import core_pkg::*; ();

	localparam int          NUM_CYCLES = 2000;
	localparam int          CLK_PERIOD = 4;
	localparam logic [31:0] SEED       = 32'hb940_031c;
	localparam logic [1:0]  EV_NONE    = 2'd0;
	localparam logic [1:0]  EV_WR      = 2'd1;
	localparam logic [1:0]  EV_OUT     = 2'd2;

	logic     clk;
	logic     rst;
	instr_t   instr;
	iaddr_t   instr_addr;
	daddr_t   mem_addr_rd;
	data_t    mem_data_rd;
	logic     mem_wr;
	daddr_t   mem_addr_wr;
	data_t    mem_data_wr;
	logic     req_in;
	io_addr_t addr_in;
	data_t    io_in;
	logic     out_en;
	io_addr_t addr_out;

	// Data memory seen by the core
	data_t data_mem [2**DADDR_W];

	//------------------------------------------------------
	// ISA model state
	//------------------------------------------------------

	data_t  model_mem [2**DADDR_W];
	data_t  io_words [2**IO_W];
	// Next fetch address
	iaddr_t model_pc;
	data_t  model_acc;
	data_t  dstack [$];
	iaddr_t cstack [$];

	// Stage-2 events, one per word
	logic [1:0] ev_kind [$];
	daddr_t     ev_addr [$];
	data_t      ev_data [$];

	// Word now on instr
	logic     cur_inn;
	operand_t cur_oper;
	logic     last_set;
	daddr_t   last_set_addr;

	logic [31:0] lfsr_state;
	int          errors;

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	stack_core UUT (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		.mem_addr_rd(mem_addr_rd),
		.mem_data_rd(mem_data_rd),
		.mem_wr     (mem_wr),
		.mem_addr_wr(mem_addr_wr),
		.mem_data_wr(mem_data_wr),
		.req_in     (req_in),
		.addr_in    (addr_in),
		.io_in      (io_in),
		.out_en     (out_en),
		.addr_out   (addr_out)
	);

	bind stack_core core_properties u_props (
		.clk       (clk),
		.rst       (rst),
		.instr_addr(instr_addr),
		.mem_wr    (mem_wr),
		.out_en    (out_en),
		.req_in    (req_in)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Pattern over all nine address bits
	function automatic data_t fill_word(input daddr_t a);
		return {a[6:0], a} ^ 16'ha5c3;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL time %0t signal %s expected %0h actual %0h",
				$time, name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	//------------------------------------------------------
	// Word generator, legal for the model's stacks
	//------------------------------------------------------

	function automatic instr_t gen_word();
		logic [OPCO_W-1:0] op;
		operand_t          oper;
		op   = 7'(rand_bits(4));
		oper = operand_t'(rand_bits(OPER_W));
		case (op)
			7'd10:
				op = JMP;
			7'd11:
				op = JIZ;
			7'd12:
				op = CAL;
			7'd13:
				op = RET;
			7'd14:
				op = LOD;
			// Undefined code, acts as NOP
			7'd15:
				op = {2'b11, 5'(rand_bits(5))};
			default: ;
		endcase
		if ((op == LOD || op == PSH || op == INN || op == CNS) && dstack.size() >= DSTACK_DEPTH)
			op = SET;
		if ((op == ADD || op == AND || op == XOR) && dstack.size() == 0)
			op = CNS;
		if (op == CAL && cstack.size() >= ISTACK_DEPTH)
			op = JMP;
		if (op == RET && cstack.size() == 0)
			op = NOP;
		// Low addresses often, so stores get read back
		if ((op == LOD || op == SET) && rand_bits(1) != 0)
			oper = {5'b0, oper[3:0]};
		if (op == LOD && last_set && rand_bits(1) != 0)
			oper = last_set_addr;
		return {op, oper};
	endfunction

	//------------------------------------------------------
	// ISA step, in program order
	//------------------------------------------------------

	task automatic step_model(input instr_t w);
		logic [OPCO_W-1:0] op;
		operand_t          oper;
		iaddr_t            next_pc;
		logic [1:0]        kind;
		data_t             old_acc;
		op      = w[OPCO_W+OPER_W-1:OPER_W];
		oper    = w[OPER_W-1:0];
		next_pc = model_pc + 1'b1;
		kind    = EV_NONE;
		old_acc = model_acc;
		case (op)
			LOD: begin
				dstack.push_back(model_acc);
				model_acc = model_mem[oper];
			end
			SET: begin
				model_mem[oper] = model_acc;
				kind = EV_WR;
			end
			PSH:
				dstack.push_back(model_acc);
			ADD:
				model_acc = dstack.pop_back() + model_acc;
			AND:
				model_acc = dstack.pop_back() & model_acc;
			XOR:
				model_acc = dstack.pop_back() ^ model_acc;
			INN: begin
				dstack.push_back(model_acc);
				model_acc = io_words[oper[IO_W-1:0]];
			end
			OUT:
				kind = EV_OUT;
			CNS: begin
				dstack.push_back(model_acc);
				model_acc = data_t'(oper);
			end
			JMP:
				next_pc = oper;
			// Accumulator after all earlier words
			JIZ:
				if (!model_acc[0])
					next_pc = oper;
			CAL: begin
				cstack.push_back(model_pc + 1'b1);
				next_pc = oper;
			end
			RET:
				next_pc = cstack.pop_back();
			default: ;
		endcase
		ev_kind.push_back(kind);
		ev_addr.push_back(oper);
		ev_data.push_back(old_acc);
		cur_inn       = (op == INN);
		cur_oper      = oper;
		last_set      = (op == SET);
		last_set_addr = oper;
		model_pc      = next_pc;
	endtask

	// Mid-cycle compare of every output
	task automatic check_cycle();
		logic [1:0] kind;
		daddr_t     addr;
		data_t      data;
		kind = ev_kind.pop_front();
		addr = ev_addr.pop_front();
		data = ev_data.pop_front();
		check_value("mem_wr", 32'(kind == EV_WR), 32'(mem_wr));
		check_value("out_en", 32'(kind == EV_OUT), 32'(out_en));
		if (kind == EV_WR) begin
			check_value("mem_addr_wr", 32'(addr), 32'(mem_addr_wr));
			check_value("mem_data_wr", 32'(data), 32'(mem_data_wr));
		end
		if (kind == EV_OUT) begin
			check_value("addr_out", 32'(addr[IO_W-1:0]), 32'(addr_out));
			check_value("mem_data_wr", 32'(data), 32'(mem_data_wr));
		end
		check_value("req_in", 32'(cur_inn), 32'(req_in));
		if (cur_inn)
			check_value("addr_in", 32'(cur_oper[IO_W-1:0]), 32'(addr_in));
		check_value("mem_addr_rd", 32'(cur_oper), 32'(mem_addr_rd));
		check_value("instr_addr", 32'(model_pc), 32'(instr_addr));
	endtask

	//------------------------------------------------------
	// Main sequence
	//------------------------------------------------------

	initial begin
		instr_t word;
		data_t  rd_word;
		data_t  io_word;
		int     i;
		instr       <= '0;
		mem_data_rd <= '0;
		io_in       <= '0;
		lfsr_state    = SEED;
		errors        = 0;
		model_pc      = '0;
		model_acc     = '0;
		cur_inn       = 1'b0;
		cur_oper      = '0;
		last_set      = 1'b0;
		last_set_addr = '0;
		for (i = 0; i < 2**DADDR_W; i++) begin
			data_mem[daddr_t'(i)]  = fill_word(daddr_t'(i));
			model_mem[daddr_t'(i)] = fill_word(daddr_t'(i));
		end
		for (i = 0; i < 2**IO_W; i++)
			io_words[io_addr_t'(i)] = data_t'(rand_bits(DATA_W));
		// Reset-cleared controls, then the reset NOP, no stage-2 event
		for (i = 0; i < 2; i++) begin
			ev_kind.push_back(EV_NONE);
			ev_addr.push_back('0);
			ev_data.push_back('0);
		end

		@(negedge clk);
		while (rst) begin
			check_value("instr_addr", 32'd0, 32'(instr_addr));
			check_value("mem_wr", 32'd0, 32'(mem_wr));
			check_value("out_en", 32'd0, 32'(out_en));
			check_value("req_in", 32'd0, 32'(req_in));
			@(negedge clk);
		end

		repeat (NUM_CYCLES) begin
			check_cycle();
			word = gen_word();
			step_model(word);
			// Write-first read, then commit the store of this edge
			if (mem_wr && mem_addr_wr == mem_addr_rd)
				rd_word = mem_data_wr;
			else
				rd_word = data_mem[mem_addr_rd];
			if (mem_wr)
				data_mem[mem_addr_wr] = mem_data_wr;
			io_word = io_words[addr_in];
			@(posedge clk);
			instr       <= word;
			mem_data_rd <= rd_word;
			io_in       <= io_word;
			@(negedge clk);
		end

		if (errors == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "Mismatches were found");
		end
	end

	// Watchdog, run length plus margin
	initial begin
		#((NUM_CYCLES + 50) * CLK_PERIOD);
		$display("Timeout: the run did not complete in the expected time");
		$display("Some tests failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

// File: vlog.f
rtl/core_pkg.sv
rtl/lifo_stack.sv
rtl/instr_fetch.sv
rtl/instr_decode.sv
rtl/execute.sv
rtl/stack_core.sv
testbench/tb_clock.sv
testbench/core_properties.sv
testbench/tb_stack_core.sv

// File: run.sh
#!/bin/sh
# Build the stack core testbench with Verilator and run it
# The exit status of the simulation is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module tb_stack_core -o sim_stack_core &&
./obj_dir/sim_stack_core ||
{ echo "Simulation build or run did not succeed"; exit 1; }
